/* hw/lsu_pkg.sv */
/*
 * Load/store unit package
 * Widths, size codes, address map and FIFO sizing constants
 */
package lsu_pkg;

    ////////////////////
    // Sizing
    localparam int NUM_BANKS = 4;
    localparam int BANK_WORDS = 256;
    localparam int REQ_QUEUE_DEPTH = 4;
    // Same as the depth of the load path (dispatch + bank read)
    localparam int ATTR_DEPTH = 2;

    localparam int REQ_PTR_W = $clog2(REQ_QUEUE_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_QUEUE_DEPTH + 1);
    localparam int ATTR_PTR_W = $clog2(ATTR_DEPTH);
    localparam int ATTR_CNT_W = $clog2(ATTR_DEPTH + 1);

    ////////////////////
    // Address map
    // Bits 9:2 pick the word, bits 11:10 the bank, the rest is ignored
    localparam int WORD_IDX_LSB = 2;
    localparam int BANK_LSB = 10;

    ////////////////////
    // Types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic signed [11:0] offset_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [3:0] req_id_t;
    typedef logic [2:0] ls_fn3_t;
    typedef logic [$clog2(NUM_BANKS)-1:0] bank_id_t;
    typedef logic [$clog2(BANK_WORDS)-1:0] word_idx_t;

    ////////////////////
    // Size codes, RISC-V funct3 style
    localparam ls_fn3_t FN3_B = 3'b000;
    localparam ls_fn3_t FN3_H = 3'b001;
    localparam ls_fn3_t FN3_W = 3'b010;
    localparam ls_fn3_t FN3_BU = 3'b100;
    localparam ls_fn3_t FN3_HU = 3'b101;

endpackage

/* hw/local_mem_bank.sv */
/*
 * Local memory bank
 * Word-wide storage, byte-enable writes, one-cycle reads
 */
`timescale 1ns/1ps

module local_mem_bank (
    input  logic               clk,
    input  logic               rst,
    input  logic               bank_req,
    input  logic               we,
    input  lsu_pkg::word_idx_t idx,
    input  lsu_pkg::byte_en_t  be,
    input  lsu_pkg::word_t     wdata,
    output logic               rvalid,
    output lsu_pkg::word_t     rdata
);

    // Contents read as zero until written
    lsu_pkg::word_t mem [lsu_pkg::BANK_WORDS] = '{default: '0};

    ////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (bank_req & we) begin
            for (int b = 0; b < $bits(lsu_pkg::byte_en_t); b++) begin
                if (be[b]) begin
                    mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        if (bank_req & ~we) begin
            rdata <= mem[idx];
        end
    end

    // Read data qualifier, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= bank_req & ~we;
        end
    end

endmodule

/* hw/lsu_request_queue.sv */
/*
 * Request front end of the load/store unit
 * Address generation, misalignment check, byte enables,
 * in-order request FIFO and credit return
 */
`timescale 1ns/1ps

module lsu_request_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_store,
    input  lsu_pkg::ls_fn3_t  req_fn3,
    input  lsu_pkg::addr_t    req_base,
    input  lsu_pkg::offset_t  req_offset,
    input  lsu_pkg::word_t    req_data,
    input  lsu_pkg::req_id_t  req_id,
    output logic              req_credit,
    output logic              err_valid,
    output lsu_pkg::req_id_t  err_id,
    output logic              q_valid,
    output logic              q_store,
    output lsu_pkg::ls_fn3_t  q_fn3,
    output lsu_pkg::addr_t    q_addr,
    output lsu_pkg::byte_en_t q_be,
    output lsu_pkg::word_t    q_data,
    output lsu_pkg::req_id_t  q_id,
    input  logic              q_pop
);

    lsu_pkg::addr_t addr;
    logic misaligned;
    lsu_pkg::byte_en_t be;
    logic push;

    logic mem_store [lsu_pkg::REQ_QUEUE_DEPTH];
    lsu_pkg::ls_fn3_t mem_fn3 [lsu_pkg::REQ_QUEUE_DEPTH];
    lsu_pkg::addr_t mem_addr [lsu_pkg::REQ_QUEUE_DEPTH];
    lsu_pkg::byte_en_t mem_be [lsu_pkg::REQ_QUEUE_DEPTH];
    lsu_pkg::word_t mem_data [lsu_pkg::REQ_QUEUE_DEPTH];
    lsu_pkg::req_id_t mem_id [lsu_pkg::REQ_QUEUE_DEPTH];

    logic [lsu_pkg::REQ_PTR_W-1:0] wr_ptr;
    logic [lsu_pkg::REQ_PTR_W-1:0] rd_ptr;
    logic [lsu_pkg::REQ_CNT_W-1:0] count;

    logic [1:0] credit_new;
    logic [lsu_pkg::REQ_CNT_W-1:0] credit_owed;

    ////////////////////
    // Address and checks
    // Cast of the signed offset sign-extends it
    assign addr = req_base + lsu_pkg::addr_t'(req_offset);

    always_comb begin
        case (req_fn3)
            lsu_pkg::FN3_H, lsu_pkg::FN3_HU: misaligned = addr[0];
            lsu_pkg::FN3_W: misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Enables only on stores
    always_comb begin
        be = '0;
        if (req_store) begin
            case (req_fn3[1:0])
                lsu_pkg::FN3_B[1:0]: be[addr[1:0]] = 1'b1;
                lsu_pkg::FN3_H[1:0]: be = 4'b0011 << addr[1:0];
                default: be = '1;
            endcase
        end
    end

    ////////////////////
    // Request FIFO
    assign push = req_valid & ~misaligned;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_store[wr_ptr] <= req_store;
            mem_fn3[wr_ptr] <= req_fn3;
            mem_addr[wr_ptr] <= addr;
            mem_be[wr_ptr] <= be;
            mem_data[wr_ptr] <= req_data;
            mem_id[wr_ptr] <= req_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, q_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign q_valid = (count != '0);
    assign q_store = mem_store[rd_ptr];
    assign q_fn3 = mem_fn3[rd_ptr];
    assign q_addr = mem_addr[rd_ptr];
    assign q_be = mem_be[rd_ptr];
    assign q_data = mem_data[rd_ptr];
    assign q_id = mem_id[rd_ptr];

    ////////////////////
    // Error report and credits
    always_ff @(posedge clk) begin
        if (rst) begin
            err_valid <= 1'b0;
        end else begin
            err_valid <= req_valid & misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid & misaligned) begin
            err_id <= req_id;
        end
    end

    // Second credit of a pop and an error in the same cycle goes out a cycle later
    assign credit_new = {1'b0, q_pop} + {1'b0, err_valid};
    assign req_credit = q_pop | err_valid | (credit_owed != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_owed <= '0;
        end else begin
            credit_owed <= credit_owed + lsu_pkg::REQ_CNT_W'(credit_new)
                           - lsu_pkg::REQ_CNT_W'(req_credit);
        end
    end

    // Requester must never spend a credit it does not hold
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> (count < lsu_pkg::REQ_QUEUE_DEPTH))
        else $error("request pushed into a full queue, credit protocol broken");

endmodule

/* hw/lsu_dispatch.sv */
/*
 * Dispatcher of the load/store unit
 * Bank decode, per-bank request fan-out, load attributes FIFO
 */
`timescale 1ns/1ps

module lsu_dispatch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            q_valid,
    input  logic                            q_store,
    input  lsu_pkg::ls_fn3_t                q_fn3,
    input  lsu_pkg::addr_t                  q_addr,
    input  lsu_pkg::byte_en_t               q_be,
    input  lsu_pkg::word_t                  q_data,
    input  lsu_pkg::req_id_t                q_id,
    output logic                            q_pop,
    output logic [lsu_pkg::NUM_BANKS-1:0]   bank_req,
    output logic                            bank_we,
    output lsu_pkg::word_idx_t              bank_idx,
    output lsu_pkg::byte_en_t               bank_be,
    output lsu_pkg::word_t                  bank_wdata,
    output logic                            attr_valid,
    output lsu_pkg::bank_id_t               attr_bank,
    output lsu_pkg::ls_fn3_t                attr_fn3,
    output logic [1:0]                      attr_byte,
    output lsu_pkg::req_id_t                attr_id,
    input  logic                            attr_pop
);

    lsu_pkg::bank_id_t bank_sel;
    logic attr_full;
    logic attr_push;

    lsu_pkg::bank_id_t attr_mem_bank [lsu_pkg::ATTR_DEPTH];
    lsu_pkg::ls_fn3_t attr_mem_fn3 [lsu_pkg::ATTR_DEPTH];
    logic [1:0] attr_mem_byte [lsu_pkg::ATTR_DEPTH];
    lsu_pkg::req_id_t attr_mem_id [lsu_pkg::ATTR_DEPTH];

    logic [lsu_pkg::ATTR_PTR_W-1:0] attr_wr_ptr;
    logic [lsu_pkg::ATTR_PTR_W-1:0] attr_rd_ptr;
    logic [lsu_pkg::ATTR_CNT_W-1:0] attr_count;

    ////////////////////
    // Issue control
    assign bank_sel = q_addr[lsu_pkg::BANK_LSB +: $bits(lsu_pkg::bank_id_t)];
    assign attr_full = (attr_count == lsu_pkg::ATTR_DEPTH);

    // Stores never wait; a load waits for room in the attributes FIFO
    assign q_pop = q_valid & (q_store | ~attr_full | attr_pop);
    assign attr_push = q_pop & ~q_store;

    always_comb begin
        bank_req = '0;
        bank_req[bank_sel] = q_pop;
    end

    // Shared by all banks except bank_req
    assign bank_we = q_store;
    assign bank_idx = q_addr[lsu_pkg::WORD_IDX_LSB +: $bits(lsu_pkg::word_idx_t)];
    assign bank_be = q_be;
    assign bank_wdata = q_data;

    ////////////////////
    // Load attributes FIFO
    always_ff @(posedge clk) begin
        if (attr_push) begin
            attr_mem_bank[attr_wr_ptr] <= bank_sel;
            attr_mem_fn3[attr_wr_ptr] <= q_fn3;
            attr_mem_byte[attr_wr_ptr] <= q_addr[1:0];
            attr_mem_id[attr_wr_ptr] <= q_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            attr_wr_ptr <= '0;
            attr_rd_ptr <= '0;
            attr_count <= '0;
        end else begin
            if (attr_push) begin
                attr_wr_ptr <= attr_wr_ptr + 1'b1;
            end
            if (attr_pop) begin
                attr_rd_ptr <= attr_rd_ptr + 1'b1;
            end
            case ({attr_push, attr_pop})
                2'b10: attr_count <= attr_count + 1'b1;
                2'b01: attr_count <= attr_count - 1'b1;
                default: attr_count <= attr_count;
            endcase
        end
    end

    assign attr_valid = (attr_count != '0);
    assign attr_bank = attr_mem_bank[attr_rd_ptr];
    assign attr_fn3 = attr_mem_fn3[attr_rd_ptr];
    assign attr_byte = attr_mem_byte[attr_rd_ptr];
    assign attr_id = attr_mem_id[attr_rd_ptr];

    // The aligner may only retire an entry that is there
    attr_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
        attr_pop |-> attr_valid)
        else $error("load attribute popped from an empty FIFO");

endmodule

/* hw/load_align.sv */
/*
 * Load result path
 * Bank read data select, byte/halfword alignment, sign extension,
 * load attributes retirement
 */
`timescale 1ns/1ps

module load_align (
    input  logic [lsu_pkg::NUM_BANKS-1:0] bank_rvalid,
    input  lsu_pkg::word_t                bank_rdata [lsu_pkg::NUM_BANKS],
    input  logic                          attr_valid,
    input  lsu_pkg::bank_id_t             attr_bank,
    input  lsu_pkg::ls_fn3_t              attr_fn3,
    input  logic [1:0]                    attr_byte,
    input  lsu_pkg::req_id_t              attr_id,
    output logic                          attr_pop,
    output logic                          ld_valid,
    output lsu_pkg::word_t                ld_data,
    output lsu_pkg::req_id_t              ld_id
);

    lsu_pkg::word_t rd_word;
    lsu_pkg::word_t shifted;

    ////////////////////
    // Result select
    assign rd_word = bank_rdata[attr_bank];

    // Addressed byte or halfword moved down to bit 0
    assign shifted = rd_word >> {attr_byte, 3'b000};

    assign ld_valid = attr_valid & bank_rvalid[attr_bank];
    assign attr_pop = ld_valid;
    assign ld_id = attr_id;

    ////////////////////
    // Extension
    always_comb begin
        case (attr_fn3)
            lsu_pkg::FN3_B: ld_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::FN3_BU: ld_data = {24'b0, shifted[7:0]};
            lsu_pkg::FN3_H: ld_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::FN3_HU: ld_data = {16'b0, shifted[15:0]};
            default: ld_data = rd_word;
        endcase
    end

    // Read data may only come back from the bank the head load went to
    always_comb begin
        if (|bank_rvalid) begin
            rvalid_matches_attr: assert final (attr_valid && $onehot(bank_rvalid)
                                               && bank_rvalid[attr_bank])
                else $error("bank read data without a matching load attribute");
        end
    end

endmodule

/* hw/load_store_unit.sv */
/*
 * Load/store unit top level
 * Request queue, dispatcher, local memory banks and load aligner
 */
`timescale 1ns/1ps

module load_store_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  logic             req_store,
    input  lsu_pkg::ls_fn3_t req_fn3,
    input  lsu_pkg::addr_t   req_base,
    input  lsu_pkg::offset_t req_offset,
    input  lsu_pkg::word_t   req_data,
    input  lsu_pkg::req_id_t req_id,
    output logic             req_credit,
    output logic             err_valid,
    output lsu_pkg::req_id_t err_id,
    output logic             ld_valid,
    output lsu_pkg::word_t   ld_data,
    output lsu_pkg::req_id_t ld_id
);

    // Queue head
    logic q_valid;
    logic q_store;
    lsu_pkg::ls_fn3_t q_fn3;
    lsu_pkg::addr_t q_addr;
    lsu_pkg::byte_en_t q_be;
    lsu_pkg::word_t q_data;
    lsu_pkg::req_id_t q_id;
    logic q_pop;

    // Bank side
    logic [lsu_pkg::NUM_BANKS-1:0] bank_req;
    logic bank_we;
    lsu_pkg::word_idx_t bank_idx;
    lsu_pkg::byte_en_t bank_be;
    lsu_pkg::word_t bank_wdata;
    logic [lsu_pkg::NUM_BANKS-1:0] bank_rvalid;
    lsu_pkg::word_t bank_rdata [lsu_pkg::NUM_BANKS];

    // Load attributes
    logic attr_valid;
    lsu_pkg::bank_id_t attr_bank;
    lsu_pkg::ls_fn3_t attr_fn3;
    logic [1:0] attr_byte;
    lsu_pkg::req_id_t attr_id;
    logic attr_pop;

    lsu_request_queue u_req_queue (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_fn3    (req_fn3),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_data   (req_data),
        .req_id     (req_id),
        .req_credit (req_credit),
        .err_valid  (err_valid),
        .err_id     (err_id),
        .q_valid    (q_valid),
        .q_store    (q_store),
        .q_fn3      (q_fn3),
        .q_addr     (q_addr),
        .q_be       (q_be),
        .q_data     (q_data),
        .q_id       (q_id),
        .q_pop      (q_pop)
    );

    lsu_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .q_valid    (q_valid),
        .q_store    (q_store),
        .q_fn3      (q_fn3),
        .q_addr     (q_addr),
        .q_be       (q_be),
        .q_data     (q_data),
        .q_id       (q_id),
        .q_pop      (q_pop),
        .bank_req   (bank_req),
        .bank_we    (bank_we),
        .bank_idx   (bank_idx),
        .bank_be    (bank_be),
        .bank_wdata (bank_wdata),
        .attr_valid (attr_valid),
        .attr_bank  (attr_bank),
        .attr_fn3   (attr_fn3),
        .attr_byte  (attr_byte),
        .attr_id    (attr_id),
        .attr_pop   (attr_pop)
    );

    ////////////////////
    // Memory banks
    for (genvar i = 0; i < lsu_pkg::NUM_BANKS; i++) begin : gen_banks
        local_mem_bank u_bank (
            .clk      (clk),
            .rst      (rst),
            .bank_req (bank_req[i]),
            .we       (bank_we),
            .idx      (bank_idx),
            .be       (bank_be),
            .wdata    (bank_wdata),
            .rvalid   (bank_rvalid[i]),
            .rdata    (bank_rdata[i])
        );
    end

    load_align u_load_align (
        .bank_rvalid (bank_rvalid),
        .bank_rdata  (bank_rdata),
        .attr_valid  (attr_valid),
        .attr_bank   (attr_bank),
        .attr_fn3    (attr_fn3),
        .attr_byte   (attr_byte),
        .attr_id     (attr_id),
        .attr_pop    (attr_pop),
        .ld_valid    (ld_valid),
        .ld_data     (ld_data),
        .ld_id       (ld_id)
    );

endmodule

/* dv/lsu_tb_checks.svh */
/*
 * Testbench helpers
 * LFSR random source, expected-value functions for the byte model,
 * compare tasks for load results and error reports
 */
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

////////////////////
// Random source
// 32-bit Fibonacci LFSR with taps 32 22 2 1
logic [31:0] lfsr_state = 32'd52;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

////////////////////
// Expected values
function automatic lsu_pkg::addr_t word_addr(input int bank, input int idx);
    return lsu_pkg::addr_t'((bank << 10) | (idx << 2));
endfunction

function automatic int size_bytes(input lsu_pkg::ls_fn3_t fn3);
    case (fn3)
        lsu_pkg::FN3_B, lsu_pkg::FN3_BU: return 1;
        lsu_pkg::FN3_H, lsu_pkg::FN3_HU: return 2;
        default: return 4;
    endcase
endfunction

function automatic logic is_misaligned(input lsu_pkg::ls_fn3_t fn3, input lsu_pkg::addr_t addr);
    return (size_bytes(fn3) == 2 && addr[0]) || (size_bytes(fn3) == 4 && addr[1:0] != 2'b00);
endfunction

// Store data stays in its own byte lanes
function automatic void apply_store(input lsu_pkg::ls_fn3_t fn3, input lsu_pkg::addr_t addr,
                                    input lsu_pkg::word_t data);
    int lane;
    for (int i = 0; i < size_bytes(fn3); i++) begin
        lane = int'(addr[1:0]) + i;
        model_mem[{addr[11:2], 2'(lane)}] = data[lane*8 +: 8];
    end
endfunction

function automatic lsu_pkg::word_t expected_load(input lsu_pkg::ls_fn3_t fn3,
                                                 input lsu_pkg::addr_t addr);
    lsu_pkg::word_t w;
    for (int i = 0; i < 4; i++) begin
        w[i*8 +: 8] = model_mem[{addr[11:2], 2'(i)}];
    end
    w = w >> (8 * int'(addr[1:0]));
    case (fn3)
        lsu_pkg::FN3_B: return {{24{w[7]}}, w[7:0]};
        lsu_pkg::FN3_BU: return {24'h0, w[7:0]};
        lsu_pkg::FN3_H: return {{16{w[15]}}, w[15:0]};
        lsu_pkg::FN3_HU: return {16'h0, w[15:0]};
        default: return w;
    endcase
endfunction

////////////////////
// Compare tasks
task automatic check_load(input string name, input lsu_pkg::word_t exp_data,
                          input lsu_pkg::word_t act_data, input lsu_pkg::req_id_t exp_id,
                          input lsu_pkg::req_id_t act_id);
    if (act_id !== exp_id) begin
        $display("ERROR %s: load id expected %0h actual %0h", name, exp_id, act_id);
        stop_on_failure();
    end else if (act_data !== exp_data) begin
        $display("ERROR %s: load data (id %0h) expected %h actual %h",
                 name, exp_id, exp_data, act_data);
        stop_on_failure();
    end
endtask

task automatic check_error(input string name, input lsu_pkg::req_id_t exp_id,
                           input lsu_pkg::req_id_t act_id);
    if (act_id !== exp_id) begin
        $display("ERROR %s: error id expected %0h actual %0h", name, exp_id, act_id);
        stop_on_failure();
    end
endtask

`endif

/* dv/lsu_tb.sv */
/*
 * Load/store unit testbench top
 * Clock, reset, credit-tracking request driver, byte model memory,
 * result and error scoreboard, watchdog
 */
`timescale 1ns/1ps

module lsu_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_WORD = 16;
    localparam int N_SUBWORD = 24;
    localparam int N_EXTEND = 13;
    localparam int N_MISALIGN = 8;
    localparam int N_RANDOM = 200;
    localparam int TOTAL_REQS = N_WORD + N_SUBWORD + N_EXTEND + N_MISALIGN + N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQS * 20;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    logic req_store;
    lsu_pkg::ls_fn3_t req_fn3;
    lsu_pkg::addr_t req_base;
    lsu_pkg::offset_t req_offset;
    lsu_pkg::word_t req_data;
    lsu_pkg::req_id_t req_id;
    logic req_credit;
    logic err_valid;
    lsu_pkg::req_id_t err_id;
    logic ld_valid;
    lsu_pkg::word_t ld_data;
    lsu_pkg::req_id_t ld_id;

    // Model state
    logic [7:0] model_mem [4096] = '{default: 8'h00};
    lsu_pkg::word_t exp_ld_data [$];
    lsu_pkg::req_id_t exp_ld_id [$];
    lsu_pkg::req_id_t exp_err_id [$];
    int credits = lsu_pkg::REQ_QUEUE_DEPTH;
    lsu_pkg::req_id_t next_id = '0;
    string test_name = "reset";

    load_store_unit dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_fn3    (req_fn3),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_data   (req_data),
        .req_id     (req_id),
        .req_credit (req_credit),
        .err_valid  (err_valid),
        .err_id     (err_id),
        .ld_valid   (ld_valid),
        .ld_data    (ld_data),
        .ld_id      (ld_id)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    `include "lsu_tb_checks.svh"

    ////////////////////
    // Driver and monitor
    // Outputs sampled on the falling edge before new inputs go out
    task automatic sample_outputs();
        lsu_pkg::word_t d;
        lsu_pkg::req_id_t id;
        if (req_credit) begin
            credits++;
            if (credits > lsu_pkg::REQ_QUEUE_DEPTH) begin
                $display("%s: more credits returned than were spent", test_name);
                stop_on_failure();
            end
        end
        if (ld_valid) begin
            if (exp_ld_id.size() == 0) begin
                $display("%s: load result with no load outstanding", test_name);
                stop_on_failure();
            end else begin
                d = exp_ld_data.pop_front();
                id = exp_ld_id.pop_front();
                check_load(test_name, d, ld_data, id, ld_id);
            end
        end
        if (err_valid) begin
            if (exp_err_id.size() == 0) begin
                $display("%s: error report for an aligned request", test_name);
                stop_on_failure();
            end else begin
                id = exp_err_id.pop_front();
                check_error(test_name, id, err_id);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        sample_outputs();
    endtask

    task automatic idle_cycle();
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic send_req(input logic store, input lsu_pkg::ls_fn3_t fn3,
                            input lsu_pkg::addr_t base, input lsu_pkg::offset_t offset,
                            input lsu_pkg::word_t data);
        lsu_pkg::addr_t addr;
        addr = base + {{20{offset[11]}}, offset};
        next_cycle();
        // Hold off while every credit is spent
        while (credits == 0) begin
            req_valid = 1'b0;
            next_cycle();
        end
        req_valid = 1'b1;
        req_store = store;
        req_fn3 = fn3;
        req_base = base;
        req_offset = offset;
        req_data = data;
        req_id = next_id;
        credits--;
        if (is_misaligned(fn3, addr)) begin
            exp_err_id.push_back(next_id);
        end else if (store) begin
            apply_store(fn3, addr, data);
        end else begin
            exp_ld_data.push_back(expected_load(fn3, addr));
            exp_ld_id.push_back(next_id);
        end
        next_id++;
    endtask

    ////////////////////
    // Tests
    initial begin
        lsu_pkg::addr_t a;
        lsu_pkg::ls_fn3_t fn3_list [5];
        fn3_list = '{lsu_pkg::FN3_B, lsu_pkg::FN3_H, lsu_pkg::FN3_W,
                     lsu_pkg::FN3_BU, lsu_pkg::FN3_HU};
        rst = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_fn3 = lsu_pkg::FN3_W;
        req_base = '0;
        req_offset = '0;
        req_data = '0;
        req_id = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "word_store_load";
        for (int b = 0; b < 4; b++) begin
            for (int k = 0; k < 2; k++) begin
                send_req(1'b1, lsu_pkg::FN3_W, word_addr(b, 8 + k), '0, rand_bits(32));
            end
        end
        for (int b = 0; b < 4; b++) begin
            for (int k = 0; k < 2; k++) begin
                // Negative offset from a base past the target
                send_req(1'b0, lsu_pkg::FN3_W, word_addr(b, 8 + k) + 32'd4, -12'sd4, '0);
            end
        end

        test_name = "subword_store";
        for (int b = 0; b < 4; b++) begin
            send_req(1'b1, lsu_pkg::FN3_W, word_addr(b, 16), '0, rand_bits(32));
            send_req(1'b1, lsu_pkg::FN3_W, word_addr(b, 17), '0, rand_bits(32));
            send_req(1'b1, lsu_pkg::FN3_B, word_addr(b, 16), 12'(b), rand_bits(32));
            send_req(1'b1, lsu_pkg::FN3_H, word_addr(b, 17), 12'((b % 2) * 2), rand_bits(32));
            send_req(1'b0, lsu_pkg::FN3_W, word_addr(b, 16), '0, '0);
            send_req(1'b0, lsu_pkg::FN3_W, word_addr(b, 17), '0, '0);
        end

        test_name = "load_extend";
        a = word_addr(2, 32);
        send_req(1'b1, lsu_pkg::FN3_W, a, '0, 32'h8001_7ffe);
        for (int i = 0; i < 4; i++) begin
            send_req(1'b0, lsu_pkg::FN3_B, a, 12'(i), '0);
            send_req(1'b0, lsu_pkg::FN3_BU, a, 12'(i), '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            send_req(1'b0, lsu_pkg::FN3_H, a, 12'(i), '0);
            send_req(1'b0, lsu_pkg::FN3_HU, a, 12'(i), '0);
        end

        test_name = "misaligned";
        a = word_addr(1, 48);
        send_req(1'b1, lsu_pkg::FN3_W, a, '0, 32'h1234_5678);
        send_req(1'b0, lsu_pkg::FN3_H, a, 12'sd1, '0);
        send_req(1'b0, lsu_pkg::FN3_W, a, 12'sd1, '0);
        send_req(1'b0, lsu_pkg::FN3_W, a, 12'sd2, '0);
        send_req(1'b0, lsu_pkg::FN3_W, a, 12'sd3, '0);
        send_req(1'b1, lsu_pkg::FN3_H, a, 12'sd3, 32'hdead_beef);
        send_req(1'b1, lsu_pkg::FN3_W, a, 12'sd2, 32'hdead_beef);
        send_req(1'b0, lsu_pkg::FN3_W, a, '0, '0);

        test_name = "random_traffic";
        for (int n = 0; n < N_RANDOM; n++) begin
            send_req(rand_bits(1), fn3_list[rand_bits(3) % 5], rand_bits(32),
                     rand_bits(12), rand_bits(32));
        end

        test_name = "drain";
        while (exp_ld_id.size() != 0 || exp_err_id.size() != 0
               || credits != lsu_pkg::REQ_QUEUE_DEPTH) begin
            idle_cycle();
        end
        // A few quiet cycles catch stray results
        repeat (4) idle_cycle();

        $display("TESTBENCH PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

/* lsu.f */
+incdir+dv
hw/lsu_pkg.sv
hw/local_mem_bank.sv
hw/lsu_request_queue.sv
hw/lsu_dispatch.sv
hw/load_align.sv
hw/load_store_unit.sv
dv/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/local_mem_bank.sv
      - hw/lsu_request_queue.sv
      - hw/lsu_dispatch.sv
      - hw/load_align.sv
      - hw/load_store_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/lsu_tb.sv
